/* vlog.f */
logic/frame_wr_pkg.sv
logic/pixel_packer.sv
logic/frame_fifo.sv
logic/frame_burst_writer.sv
logic/frame_writer_top.sv
bench/frame_mem_checker.sv
bench/tb_frame_writer.sv

/* Makefile */
SIM = obj_dir/Vtb_frame_writer

$(SIM): vlog.f $(wildcard logic/*.sv) $(wildcard bench/*.sv)
	verilator --binary --timing --assert -Wno-fatal --top-module tb_frame_writer -f vlog.f

run: $(SIM)
	./$(SIM) | tee sim.log
	grep -q "Simulation completed successfully" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: run clean

/* bench/tb_frame_writer.sv */
module tb_frame_writer;
	timeunit 1ns;
	timeprecision 100ps;
	import frame_wr_pkg::*;

	// Bursts over all tests with the aborted frame counted in full
	localparam int total_bursts = 24;
	localparam int cycle_limit  = 200 * total_bursts + 2000;

	logic         M_AXI_ACLK;
	logic         M_AXI_ARESETN;
	logic         soft_resetn;
	logic         resetting;
	logic         pixel_valid;
	logic         pixel_sof;
	pixel_t       pixel;
	img_w_t       img_width;
	img_h_t       img_height;
	axi_addr_t    base_addr;
	logic         frame_pulse;
	logic         overflow;
	axi_addr_t    awaddr;
	logic [7:0]   awlen;
	logic [2:0]   awsize;
	logic [1:0]   awburst;
	logic [3:0]   awcache;
	logic [2:0]   awprot;
	logic         awvalid;
	logic         awready;
	axi_data_t    wdata;
	logic [3:0]   wstrb;
	logic         wlast;
	logic         wvalid;
	logic         wready;
	logic [1:0]   bresp;
	logic         bvalid;
	logic         bready;
	logic         stall_heavy;
	logic         model_we;
	axi_addr_t    model_addr;
	axi_data_t    model_data;
	logic [3:0]   test_id;
	logic         test_end;
	int           exp_pulses;
	int           pass_count;
	int           fail_count;
	int           cycles;

	pixel_t       pix_q [$];
	axi_data_t    word_q [$];

	frame_writer_top u_dut (
		.M_AXI_ACLK    (M_AXI_ACLK),
		.M_AXI_ARESETN (M_AXI_ARESETN),
		.soft_resetn   (soft_resetn),
		.resetting     (resetting),
		.pixel_valid   (pixel_valid),
		.pixel_sof     (pixel_sof),
		.pixel         (pixel),
		.img_width     (img_width),
		.img_height    (img_height),
		.base_addr     (base_addr),
		.frame_pulse   (frame_pulse),
		.overflow      (overflow),
		.M_AXI_AWADDR  (awaddr),
		.M_AXI_AWLEN   (awlen),
		.M_AXI_AWSIZE  (awsize),
		.M_AXI_AWBURST (awburst),
		.M_AXI_AWCACHE (awcache),
		.M_AXI_AWPROT  (awprot),
		.M_AXI_AWVALID (awvalid),
		.M_AXI_AWREADY (awready),
		.M_AXI_WDATA   (wdata),
		.M_AXI_WSTRB   (wstrb),
		.M_AXI_WLAST   (wlast),
		.M_AXI_WVALID  (wvalid),
		.M_AXI_WREADY  (wready),
		.M_AXI_BRESP   (bresp),
		.M_AXI_BVALID  (bvalid),
		.M_AXI_BREADY  (bready)
	);

	frame_mem_checker u_checker (
		.M_AXI_ACLK    (M_AXI_ACLK),
		.M_AXI_ARESETN (M_AXI_ARESETN),
		.M_AXI_AWADDR  (awaddr),
		.M_AXI_AWLEN   (awlen),
		.M_AXI_AWSIZE  (awsize),
		.M_AXI_AWBURST (awburst),
		.M_AXI_AWCACHE (awcache),
		.M_AXI_AWPROT  (awprot),
		.M_AXI_AWVALID (awvalid),
		.M_AXI_AWREADY (awready),
		.M_AXI_WDATA   (wdata),
		.M_AXI_WSTRB   (wstrb),
		.M_AXI_WLAST   (wlast),
		.M_AXI_WVALID  (wvalid),
		.M_AXI_WREADY  (wready),
		.M_AXI_BRESP   (bresp),
		.M_AXI_BVALID  (bvalid),
		.M_AXI_BREADY  (bready),
		.resetting     (resetting),
		.frame_pulse   (frame_pulse),
		.overflow      (overflow),
		.stall_heavy   (stall_heavy),
		.model_we      (model_we),
		.model_addr    (model_addr),
		.model_data    (model_data),
		.test_id       (test_id),
		.test_end      (test_end),
		.exp_pulses    (exp_pulses),
		.pass_count    (pass_count),
		.fail_count    (fail_count)
	);

	initial begin
		M_AXI_ACLK = 1'b0;
		forever #2 M_AXI_ACLK = ~M_AXI_ACLK;
	end

	always @(posedge M_AXI_ACLK) begin
		cycles <= cycles + 1;
		if (cycles >= cycle_limit) begin
			$display("Timeout after %0d cycles, the DUT stopped making progress", cycles);
			$display("Simulation failed");
			$finish;
		end
	end

	// Random frame with pixel 0 in the low byte of word 0
	task automatic build_frame(input int w, input int h);
		pix_q.delete();
		word_q.delete();
		for (int i = 0; i < w * h; i++)
			pix_q.push_back(pixel_t'($urandom));
		for (int k = 0; k < w * h / 4; k++)
			word_q.push_back({pix_q[4*k+3], pix_q[4*k+2], pix_q[4*k+1], pix_q[4*k]});
	endtask

	task automatic load_model(input axi_addr_t base);
		for (int i = 0; i < word_q.size(); i++) begin
			model_we   <= 1'b1;
			model_addr <= base + axi_addr_t'(4 * i);
			model_data <= word_q[i];
			@(posedge M_AXI_ACLK);
		end
		model_we <= 1'b0;
	endtask

	task automatic send_pixels(input int n);
		for (int i = 0; i < n; i++) begin
			while ($urandom % 4 == 0) begin
				pixel_valid <= 1'b0;
				pixel_sof   <= 1'b0;
				@(posedge M_AXI_ACLK);
			end
			pixel_valid <= 1'b1;
			pixel_sof   <= (i == 0);
			pixel       <= pix_q[i];
			@(posedge M_AXI_ACLK);
		end
		pixel_valid <= 1'b0;
		pixel_sof   <= 1'b0;
	endtask

	task automatic prepare_frame(input int w, input int h, input axi_addr_t base);
		build_frame(w, h);
		img_width  <= img_w_t'(w);
		img_height <= img_h_t'(h);
		base_addr  <= base;
		load_model(base);
	endtask

	task automatic run_frame(input int w, input int h, input axi_addr_t base);
		prepare_frame(w, h, base);
		send_pixels(pix_q.size());
		do
			@(posedge M_AXI_ACLK);
		while (!frame_pulse);
	endtask

	task automatic close_test(input int pulses);
		exp_pulses <= pulses;
		test_end   <= 1'b1;
		@(posedge M_AXI_ACLK);
		test_end   <= 1'b0;
		@(posedge M_AXI_ACLK);
	endtask

	// ------------------------------
	// Test sequence
	// ------------------------------
	initial begin
		void'($urandom(32'h6632_6c06));
		cycles        <= 0;
		M_AXI_ARESETN <= 1'b0;
		soft_resetn   <= 1'b1;
		pixel_valid   <= 1'b0;
		pixel_sof     <= 1'b0;
		pixel         <= '0;
		img_width     <= img_w_t'(64);
		img_height    <= img_h_t'(4);
		base_addr     <= '0;
		stall_heavy   <= 1'b0;
		model_we      <= 1'b0;
		model_addr    <= '0;
		model_data    <= '0;
		test_id       <= 4'd0;
		test_end      <= 1'b0;
		exp_pulses    <= 0;
		repeat (16) @(posedge M_AXI_ACLK);
		M_AXI_ARESETN <= 1'b1;

		test_id <= 4'd1;
		repeat (8) @(posedge M_AXI_ACLK);
		close_test(0);

		test_id <= 4'd2;
		run_frame(64, 4, 32'h0000_1000);
		close_test(1);

		test_id <= 4'd3;
		run_frame(32, 4, 32'h0000_2000);
		run_frame(48, 8, 32'h0000_8000);
		close_test(2);

		test_id     <= 4'd4;
		stall_heavy <= 1'b1;
		run_frame(64, 4, 32'h0000_3000);
		stall_heavy <= 1'b0;
		close_test(1);

		// Abort just after the second burst has started
		test_id <= 4'd5;
		prepare_frame(64, 4, 32'h0000_4000);
		send_pixels(134);
		soft_resetn <= 1'b0;
		repeat (4) @(posedge M_AXI_ACLK);
		soft_resetn <= 1'b1;
		do
			@(posedge M_AXI_ACLK);
		while (resetting);
		run_frame(64, 4, 32'h0000_4000);
		close_test(1);

		repeat (4) @(posedge M_AXI_ACLK);
		$display("Tests passed: %0d, failed: %0d", pass_count, fail_count);
		if (fail_count == 0 && pass_count == 5)
			$display("Simulation completed successfully");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

/* bench/frame_mem_checker.sv */
module frame_mem_checker (
	input  logic                       M_AXI_ACLK,
	input  logic                       M_AXI_ARESETN,
	input  frame_wr_pkg::axi_addr_t    M_AXI_AWADDR,
	input  logic [7:0]                 M_AXI_AWLEN,
	input  logic [2:0]                 M_AXI_AWSIZE,
	input  logic [1:0]                 M_AXI_AWBURST,
	input  logic [3:0]                 M_AXI_AWCACHE,
	input  logic [2:0]                 M_AXI_AWPROT,
	input  logic                       M_AXI_AWVALID,
	output logic                       M_AXI_AWREADY,
	input  frame_wr_pkg::axi_data_t    M_AXI_WDATA,
	input  logic [3:0]                 M_AXI_WSTRB,
	input  logic                       M_AXI_WLAST,
	input  logic                       M_AXI_WVALID,
	output logic                       M_AXI_WREADY,
	output logic [1:0]                 M_AXI_BRESP,
	output logic                       M_AXI_BVALID,
	input  logic                       M_AXI_BREADY,
	input  logic                       resetting,
	input  logic                       frame_pulse,
	input  logic                       overflow,
	input  logic                       stall_heavy,
	input  logic                       model_we,
	input  frame_wr_pkg::axi_addr_t    model_addr,
	input  frame_wr_pkg::axi_data_t    model_data,
	input  logic [3:0]                 test_id,
	input  logic                       test_end,
	input  int                         exp_pulses,
	output int                         pass_count,
	output int                         fail_count
);
	timeunit 1ns;
	timeprecision 100ps;
	import frame_wr_pkg::*;

	axi_data_t   exp_mem [axi_addr_t];
	bit          pending [axi_addr_t];
	axi_data_t   w_buf [$];
	bit          w_fill [$];
	axi_addr_t   aw_q [$];
	logic        w_done;
	logic        b_due;
	int          b_wait;
	logic        burst_open;
	logic        drain;
	logic        first_cycle;
	logic        ovf_seen;
	logic [6:0]  aw_attr;
	logic        attr_seen;
	int          test_errs;
	int          pulses;
	int          drains;

	initial begin
		M_AXI_AWREADY = 1'b0;
		M_AXI_WREADY  = 1'b0;
		M_AXI_BRESP   = 2'b00;
		M_AXI_BVALID  = 1'b0;
		pass_count    = 0;
		fail_count    = 0;
		test_errs     = 0;
		pulses        = 0;
		drains        = 0;
		ovf_seen      = 1'b0;
	end

	function automatic string test_name(input logic [3:0] id);
		case (id)
			4'd1:    return "after_reset";
			4'd2:    return "single_frame";
			4'd3:    return "two_frames";
			4'd4:    return "bus_stalls";
			4'd5:    return "soft_reset";
			default: return "idle";
		endcase
	endfunction

	task automatic note_error(input string msg);
		$display("Error in test %s: %s", test_name(test_id), msg);
		test_errs++;
	endtask

	task automatic value_mismatch(input string what, input logic [31:0] exp_v,
		input logic [31:0] act_v);
		$display("FAIL %s %s expected %h actual %h", test_name(test_id), what, exp_v, act_v);
		test_errs++;
	endtask

	// Compare one finished burst and skip filler beats
	task automatic store_burst(input axi_addr_t addr);
		axi_addr_t a;
		for (int i = 0; i < w_buf.size(); i++) begin
			a = addr + axi_addr_t'(4 * i);
			if (w_fill[i])
				continue;
			if (!exp_mem.exists(a)) begin
				note_error($sformatf("write to %h lies outside the frame", a));
			end else if (exp_mem[a] != w_buf[i]) begin
				value_mismatch($sformatf("word at %h", a), exp_mem[a], w_buf[i]);
			end else begin
				if (!pending[a])
					note_error($sformatf("word at %h was written twice", a));
				pending[a] = 1'b0;
			end
		end
		w_buf.delete();
		w_fill.delete();
		w_done = 1'b0;
	endtask

	task automatic report_test();
		int missing;
		missing = 0;
		foreach (pending[a])
			if (pending[a])
				missing++;
		if (missing != 0)
			note_error($sformatf("%0d words of the frame were never written", missing));
		if (pulses != exp_pulses)
			value_mismatch("frame pulse count", exp_pulses, pulses);
		if (test_id == 4'd1 && resetting)
			note_error("resetting is still high after reset");
		if (test_id == 4'd5 && drains == 0)
			note_error("soft reset did not meet an open burst");
		if (test_errs == 0) begin
			$display("test %s: passed", test_name(test_id));
			pass_count++;
		end else begin
			$display("test %s: failed with %0d errors", test_name(test_id), test_errs);
			fail_count++;
		end
		test_errs = 0;
		pulses    = 0;
		drains    = 0;
	endtask

	// ------------------------------
	// Slave and scoreboard
	// ------------------------------
	always @(posedge M_AXI_ACLK) begin
		int stall_mod;
		stall_mod = stall_heavy ? 2 : 4;
		if (model_we) begin
			exp_mem[model_addr] = model_data;
			pending[model_addr] = 1'b1;
		end
		if (!M_AXI_ARESETN) begin
			M_AXI_AWREADY <= 1'b0;
			M_AXI_WREADY  <= 1'b0;
			M_AXI_BVALID  <= 1'b0;
			w_buf.delete();
			w_fill.delete();
			aw_q.delete();
			w_done      = 1'b0;
			b_due       = 1'b0;
			burst_open  = 1'b0;
			drain       = 1'b0;
			first_cycle = 1'b1;
			attr_seen   = 1'b0;
			if (!resetting)
				note_error("resetting is low while reset is applied");
		end else begin
			M_AXI_AWREADY <= ($urandom % stall_mod) != 0;
			M_AXI_WREADY  <= ($urandom % stall_mod) != 0;
			if (first_cycle) begin
				if (frame_pulse || overflow || M_AXI_AWVALID || M_AXI_WVALID)
					note_error("outputs not idle right after reset");
				first_cycle = 1'b0;
			end
			if (M_AXI_AWVALID && M_AXI_AWREADY) begin
				aw_q.push_back(M_AXI_AWADDR);
				burst_open = 1'b1;
				if (M_AXI_AWLEN != 8'(burst_len - 1))
					value_mismatch("AWLEN", 32'(burst_len - 1), 32'(M_AXI_AWLEN));
				// Four byte beats, incrementing
				if (M_AXI_AWSIZE != 3'd2)
					value_mismatch("AWSIZE", 32'd2, 32'(M_AXI_AWSIZE));
				if (M_AXI_AWBURST != 2'b01)
					value_mismatch("AWBURST", 32'd1, 32'(M_AXI_AWBURST));
				if (!attr_seen) begin
					aw_attr   = {M_AXI_AWCACHE, M_AXI_AWPROT};
					attr_seen = 1'b1;
				end else if ({M_AXI_AWCACHE, M_AXI_AWPROT} != aw_attr) begin
					value_mismatch("AWCACHE and AWPROT", 32'(aw_attr),
						32'({M_AXI_AWCACHE, M_AXI_AWPROT}));
				end
				if (M_AXI_AWADDR % burst_bytes != 0)
					note_error($sformatf("burst address %h not 64 byte aligned", M_AXI_AWADDR));
			end
			if (M_AXI_WVALID && M_AXI_WREADY) begin
				burst_open = 1'b1;
				if (M_AXI_WLAST != (w_buf.size() == burst_len - 1))
					note_error("WLAST is not on the 16th beat");
				if (M_AXI_WSTRB != 4'hf)
					value_mismatch("WSTRB", 32'hf, 32'(M_AXI_WSTRB));
				w_buf.push_back(M_AXI_WDATA);
				w_fill.push_back(resetting);
				if (M_AXI_WLAST)
					w_done = 1'b1;
			end
			if (M_AXI_BREADY != M_AXI_BVALID)
				note_error("BREADY does not follow BVALID");
			// BREADY follows BVALID, so a raised BVALID completes now
			if (M_AXI_BVALID) begin
				M_AXI_BVALID <= 1'b0;
				burst_open = 1'b0;
				drain      = 1'b0;
			end
			if (resetting && burst_open && !drain) begin
				drain = 1'b1;
				drains++;
			end
			if (drain && !resetting) begin
				note_error("resetting fell before the open burst got its response");
				drain = 1'b0;
			end
			if (w_done && aw_q.size() != 0 && !b_due && !M_AXI_BVALID) begin
				store_burst(aw_q.pop_front());
				b_due  = 1'b1;
				b_wait = $urandom % 4;
			end else if (b_due) begin
				if (b_wait == 0) begin
					M_AXI_BVALID <= 1'b1;
					M_AXI_BRESP  <= 2'b00;
					b_due = 1'b0;
				end else begin
					b_wait--;
				end
			end
			if (frame_pulse)
				pulses++;
			if (overflow && !ovf_seen) begin
				note_error("FIFO overflow was flagged");
				ovf_seen = 1'b1;
			end
			if (test_end)
				report_test();
		end
	end

endmodule

/* logic/frame_writer_top.sv */
module frame_writer_top (
	input  logic                       M_AXI_ACLK,
	input  logic                       M_AXI_ARESETN,
	input  logic                       soft_resetn,
	output logic                       resetting,
	input  logic                       pixel_valid,
	input  logic                       pixel_sof,
	input  frame_wr_pkg::pixel_t       pixel,
	input  frame_wr_pkg::img_w_t       img_width,
	input  frame_wr_pkg::img_h_t       img_height,
	input  frame_wr_pkg::axi_addr_t    base_addr,
	output logic                       frame_pulse,
	output logic                       overflow,
	output frame_wr_pkg::axi_addr_t    M_AXI_AWADDR,
	output logic [7:0]                 M_AXI_AWLEN,
	output logic [2:0]                 M_AXI_AWSIZE,
	output logic [1:0]                 M_AXI_AWBURST,
	output logic [3:0]                 M_AXI_AWCACHE,
	output logic [2:0]                 M_AXI_AWPROT,
	output logic                       M_AXI_AWVALID,
	input  logic                       M_AXI_AWREADY,
	output frame_wr_pkg::axi_data_t    M_AXI_WDATA,
	output logic [3:0]                 M_AXI_WSTRB,
	output logic                       M_AXI_WLAST,
	output logic                       M_AXI_WVALID,
	input  logic                       M_AXI_WREADY,
	input  logic [1:0]                 M_AXI_BRESP,
	input  logic                       M_AXI_BVALID,
	output logic                       M_AXI_BREADY
);
	import frame_wr_pkg::*;

	logic          wr_en;
	axi_data_t     wr_data;
	logic          rd_en;
	axi_data_t     rd_data;
	logic          empty;
	fifo_count_t   rd_count;

	// Packer and FIFO are cleared while the writer is resetting
	pixel_packer u_packer (
		.M_AXI_ACLK    (M_AXI_ACLK),
		.M_AXI_ARESETN (M_AXI_ARESETN),
		.flush         (resetting),
		.pixel_valid   (pixel_valid),
		.pixel_sof     (pixel_sof),
		.pixel         (pixel),
		.wr_en         (wr_en),
		.wr_data       (wr_data)
	);

	frame_fifo u_fifo (
		.M_AXI_ACLK    (M_AXI_ACLK),
		.M_AXI_ARESETN (M_AXI_ARESETN),
		.flush         (resetting),
		.wr_en         (wr_en),
		.wr_data       (wr_data),
		.rd_en         (rd_en),
		.rd_data       (rd_data),
		.empty         (empty),
		.rd_count      (rd_count),
		.overflow      (overflow)
	);

	frame_burst_writer u_writer (
		.M_AXI_ACLK    (M_AXI_ACLK),
		.M_AXI_ARESETN (M_AXI_ARESETN),
		.soft_resetn   (soft_resetn),
		.resetting     (resetting),
		.img_width     (img_width),
		.img_height    (img_height),
		.base_addr     (base_addr),
		.din           (rd_data),
		.empty         (empty),
		.rd_count      (rd_count),
		.rd_en         (rd_en),
		.frame_pulse   (frame_pulse),
		.M_AXI_AWADDR  (M_AXI_AWADDR),
		.M_AXI_AWLEN   (M_AXI_AWLEN),
		.M_AXI_AWSIZE  (M_AXI_AWSIZE),
		.M_AXI_AWBURST (M_AXI_AWBURST),
		.M_AXI_AWCACHE (M_AXI_AWCACHE),
		.M_AXI_AWPROT  (M_AXI_AWPROT),
		.M_AXI_AWVALID (M_AXI_AWVALID),
		.M_AXI_AWREADY (M_AXI_AWREADY),
		.M_AXI_WDATA   (M_AXI_WDATA),
		.M_AXI_WSTRB   (M_AXI_WSTRB),
		.M_AXI_WLAST   (M_AXI_WLAST),
		.M_AXI_WVALID  (M_AXI_WVALID),
		.M_AXI_WREADY  (M_AXI_WREADY),
		.M_AXI_BRESP   (M_AXI_BRESP),
		.M_AXI_BVALID  (M_AXI_BVALID),
		.M_AXI_BREADY  (M_AXI_BREADY)
	);

endmodule

/* logic/frame_burst_writer.sv */
module frame_burst_writer (
	input  logic                       M_AXI_ACLK,
	input  logic                       M_AXI_ARESETN,
	input  logic                       soft_resetn,
	output logic                       resetting,
	input  frame_wr_pkg::img_w_t       img_width,
	input  frame_wr_pkg::img_h_t       img_height,
	input  frame_wr_pkg::axi_addr_t    base_addr,
	input  frame_wr_pkg::axi_data_t    din,
	input  logic                       empty,
	input  frame_wr_pkg::fifo_count_t  rd_count,
	output logic                       rd_en,
	output logic                       frame_pulse,
	output frame_wr_pkg::axi_addr_t    M_AXI_AWADDR,
	output logic [7:0]                 M_AXI_AWLEN,
	output logic [2:0]                 M_AXI_AWSIZE,
	output logic [1:0]                 M_AXI_AWBURST,
	output logic [3:0]                 M_AXI_AWCACHE,
	output logic [2:0]                 M_AXI_AWPROT,
	output logic                       M_AXI_AWVALID,
	input  logic                       M_AXI_AWREADY,
	output frame_wr_pkg::axi_data_t    M_AXI_WDATA,
	output logic [3:0]                 M_AXI_WSTRB,
	output logic                       M_AXI_WLAST,
	output logic                       M_AXI_WVALID,
	input  logic                       M_AXI_WREADY,
	input  logic [1:0]                 M_AXI_BRESP,
	input  logic                       M_AXI_BVALID,
	output logic                       M_AXI_BREADY
);
	import frame_wr_pkg::*;

	logic        soft_resetn_d1;
	logic        soft_edge;
	logic        soft_resetting;
	logic        start_burst;
	logic        start_d1;
	logic        burst_active;
	logic        need_data;
	logic        dvalid;
	logic        w_open;
	logic        wnext;
	logic        final_data;
	logic        axi_awvalid;
	logic        axi_wlast;
	axi_addr_t   axi_awaddr;
	beat_idx_t   write_index;
	img_w_t      col_idx;
	img_h_t      row_idx;

	// ------------------------------
	// Soft reset
	// ------------------------------
	always_ff @(posedge M_AXI_ACLK) begin
		if (!M_AXI_ARESETN)
			soft_resetn_d1 <= 1'b0;
		else
			soft_resetn_d1 <= soft_resetn;
	end

	assign soft_edge = soft_resetn_d1 && !soft_resetn;

	// Open burst is drained with filler beats until its response
	always_ff @(posedge M_AXI_ACLK) begin
		if (!M_AXI_ARESETN || M_AXI_BVALID)
			soft_resetting <= 1'b0;
		else if (soft_edge && (start_burst || burst_active))
			soft_resetting <= 1'b1;
	end

	assign resetting = !M_AXI_ARESETN || soft_resetting || !soft_resetn;

	// Fixed burst attributes
	assign M_AXI_AWADDR  = axi_awaddr;
	assign M_AXI_AWLEN   = 8'(burst_len - 1);
	assign M_AXI_AWSIZE  = 3'($clog2(data_w / 8));
	assign M_AXI_AWBURST = 2'b01;
	assign M_AXI_AWCACHE = 4'b0010;
	assign M_AXI_AWPROT  = 3'b000;
	assign M_AXI_AWVALID = axi_awvalid;
	assign M_AXI_WDATA   = din;
	assign M_AXI_WSTRB   = '1;
	assign M_AXI_WLAST   = axi_wlast;
	assign M_AXI_WVALID  = dvalid || (soft_resetting && w_open);
	assign M_AXI_BREADY  = M_AXI_BVALID;

	assign wnext = M_AXI_WVALID && M_AXI_WREADY;
	assign rd_en = need_data && (!dvalid || M_AXI_WREADY) && soft_resetn && !soft_resetting;

	// ------------------------------
	// Burst start and address
	// ------------------------------
	always_ff @(posedge M_AXI_ACLK) begin
		if (!M_AXI_ARESETN) begin
			start_burst  <= 1'b0;
			start_d1     <= 1'b0;
			burst_active <= 1'b0;
		end else begin
			start_burst <= !start_burst && !burst_active && soft_resetn
				&& (rd_count >= fifo_count_t'(burst_len));
			start_d1    <= start_burst;
			if (start_burst)
				burst_active <= 1'b1;
			else if (M_AXI_BVALID)
				burst_active <= 1'b0;
		end
	end

	always_ff @(posedge M_AXI_ACLK) begin
		if (!M_AXI_ARESETN)
			axi_awvalid <= 1'b0;
		else if (start_d1)
			axi_awvalid <= 1'b1;
		else if (M_AXI_AWREADY)
			axi_awvalid <= 1'b0;
	end

	// First burst of a frame restarts at the base address
	always_ff @(posedge M_AXI_ACLK) begin
		if (!M_AXI_ARESETN)
			axi_awaddr <= '0;
		else if (start_burst)
			axi_awaddr <= final_data ? base_addr : axi_awaddr + axi_addr_t'(burst_bytes);
	end

	// ------------------------------
	// Data beats
	// ------------------------------
	always_ff @(posedge M_AXI_ACLK) begin
		if (!M_AXI_ARESETN) begin
			need_data   <= 1'b0;
			dvalid      <= 1'b0;
			w_open      <= 1'b0;
			axi_wlast   <= 1'b0;
			write_index <= beat_idx_t'(burst_len - 1);
		end else begin
			if (start_burst)
				need_data <= 1'b1;
			else if (wnext && write_index == beat_idx_t'(1))
				need_data <= 1'b0;
			// Word from the FIFO shows up one cycle after rd_en
			if (rd_en)
				dvalid <= 1'b1;
			else if (M_AXI_WREADY)
				dvalid <= 1'b0;
			if (start_burst)
				w_open <= 1'b1;
			else if (wnext && axi_wlast)
				w_open <= 1'b0;
			if (wnext)
				axi_wlast <= (write_index == beat_idx_t'(1));
			if (start_burst)
				write_index <= beat_idx_t'(burst_len - 1);
			else if (wnext && write_index != '0)
				write_index <= write_index - 1'b1;
		end
	end

	// ------------------------------
	// Frame position
	// ------------------------------
	assign final_data = (col_idx == '0) && (row_idx == '0);

	always_ff @(posedge M_AXI_ACLK) begin
		if (!M_AXI_ARESETN || !soft_resetn || soft_resetting) begin
			col_idx <= '0;
			row_idx <= '0;
		end else if (start_burst && final_data) begin
			col_idx <= img_width - img_w_t'(word_pixels);
			row_idx <= img_height - 1'b1;
		end else if (wnext) begin
			if (col_idx != '0) begin
				col_idx <= col_idx - img_w_t'(word_pixels);
			end else if (row_idx != '0) begin
				col_idx <= img_width - img_w_t'(word_pixels);
				row_idx <= row_idx - 1'b1;
			end
		end
	end

	// Aborted frames give no pulse
	always_ff @(posedge M_AXI_ACLK) begin
		if (!M_AXI_ARESETN)
			frame_pulse <= 1'b0;
		else
			frame_pulse <= M_AXI_BVALID && final_data && soft_resetn && !soft_resetting;
	end

	// ------------------------------
	// Checks
	// ------------------------------
	aw_stable: assert property (@(posedge M_AXI_ACLK) disable iff (!M_AXI_ARESETN)
		M_AXI_AWVALID && !M_AXI_AWREADY |=> M_AXI_AWVALID && $stable(M_AXI_AWADDR));

	wlast_with_wvalid: assert property (@(posedge M_AXI_ACLK) disable iff (!M_AXI_ARESETN)
		M_AXI_WLAST |-> M_AXI_WVALID);

	bresp_okay: assert property (@(posedge M_AXI_ACLK) disable iff (!M_AXI_ARESETN)
		M_AXI_BVALID |-> M_AXI_BRESP == 2'b00);

	// Words counted at the start are still there when reads begin
	fifo_filled: assert property (@(posedge M_AXI_ACLK)
		disable iff (!M_AXI_ARESETN || resetting)
		start_burst |=> !empty);

endmodule

/* logic/frame_fifo.sv */
module frame_fifo (
	input  logic                       M_AXI_ACLK,
	input  logic                       M_AXI_ARESETN,
	input  logic                       flush,
	input  logic                       wr_en,
	input  frame_wr_pkg::axi_data_t    wr_data,
	input  logic                       rd_en,
	output frame_wr_pkg::axi_data_t    rd_data,
	output logic                       empty,
	output frame_wr_pkg::fifo_count_t  rd_count,
	output logic                       overflow
);
	import frame_wr_pkg::*;

	axi_data_t               mem [fifo_depth];
	logic [fifo_ptr_w-1:0]   wr_ptr;
	logic [fifo_ptr_w-1:0]   rd_ptr;
	fifo_count_t             count;
	logic                    full;
	logic                    do_wr;
	logic                    do_rd;

	assign full     = (count == fifo_count_t'(fifo_depth));
	assign empty    = (count == '0);
	assign rd_count = count;
	assign do_wr    = wr_en && !full;
	assign do_rd    = rd_en && !empty;

	// ------------------------------
	// Pointers and fill level
	// ------------------------------
	always_ff @(posedge M_AXI_ACLK) begin
		if (!M_AXI_ARESETN || flush) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_wr)
				wr_ptr <= wr_ptr + 1'b1;
			if (do_rd)
				rd_ptr <= rd_ptr + 1'b1;
			case ({do_wr, do_rd})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// Sticky until reset or flush
	always_ff @(posedge M_AXI_ACLK) begin
		if (!M_AXI_ARESETN || flush)
			overflow <= 1'b0;
		else if (wr_en && full)
			overflow <= 1'b1;
	end

	// Storage and registered read port
	always_ff @(posedge M_AXI_ACLK) begin
		if (do_wr)
			mem[wr_ptr] <= wr_data;
		if (do_rd)
			rd_data <= mem[rd_ptr];
	end

	// The writer only pops words it has seen counted
	rd_not_empty: assert property (@(posedge M_AXI_ACLK) disable iff (!M_AXI_ARESETN)
		rd_en |-> !empty);

endmodule

/* logic/pixel_packer.sv */
module pixel_packer (
	input  logic                     M_AXI_ACLK,
	input  logic                     M_AXI_ARESETN,
	input  logic                     flush,
	input  logic                     pixel_valid,
	input  logic                     pixel_sof,
	input  frame_wr_pkg::pixel_t     pixel,
	output logic                     wr_en,
	output frame_wr_pkg::axi_data_t  wr_data
);
	import frame_wr_pkg::*;

	logic                             aligned;
	logic                             accept;
	logic [$clog2(word_pixels)-1:0]   lane;
	axi_data_t                        shift_word;

	// Pixels before the first start of frame are dropped
	assign accept  = pixel_valid && (aligned || pixel_sof);
	assign wr_data = shift_word;

	// ------------------------------
	// Lane tracking
	// ------------------------------
	always_ff @(posedge M_AXI_ACLK) begin
		if (!M_AXI_ARESETN || flush) begin
			aligned <= 1'b0;
			lane    <= '0;
			wr_en   <= 1'b0;
		end else begin
			wr_en <= 1'b0;
			if (accept) begin
				aligned <= 1'b1;
				if (pixel_sof) begin
					// Start of frame pixel always sits in lane 0
					lane <= 1;
				end else begin
					lane  <= lane + 1'b1;
					wr_en <= (lane == word_pixels - 1);
				end
			end
		end
	end

	// Shift in from the top, first pixel ends up in the low byte
	always_ff @(posedge M_AXI_ACLK) begin
		if (accept)
			shift_word <= {pixel, shift_word[data_w-1:pix_w]};
	end

endmodule

/* logic/frame_wr_pkg.sv */
package frame_wr_pkg;

	// ------------------------------
	// Bus widths
	// ------------------------------
	localparam int data_w = 32;
	localparam int addr_w = 32;

	// Pixel format
	localparam int pix_w       = 8;
	localparam int word_pixels = data_w / pix_w;

	// ------------------------------
	// Burst shape
	// ------------------------------
	localparam int burst_len   = 16;
	localparam int burst_bytes = burst_len * data_w / 8;

	// Image geometry
	localparam int img_wbits = 12;
	localparam int img_hbits = 12;

	// ------------------------------
	// Word FIFO
	// ------------------------------
	localparam int fifo_depth = 64;
	localparam int fifo_ptr_w = $clog2(fifo_depth);
	// One extra bit so a full FIFO can be told from an empty one
	localparam int count_w    = fifo_ptr_w + 1;

	typedef logic [data_w-1:0]    axi_data_t;
	typedef logic [addr_w-1:0]    axi_addr_t;
	typedef logic [pix_w-1:0]     pixel_t;
	typedef logic [img_wbits-1:0] img_w_t;
	typedef logic [img_hbits-1:0] img_h_t;
	typedef logic [count_w-1:0]   fifo_count_t;

	// Beat index inside a burst
	typedef logic [$clog2(burst_len):0] beat_idx_t;

endpackage
